// File: src/csr_pkg.sv
package csr_pkg;

   // CSR instruction operations, encoded as in the funct3 low bits.
   typedef enum logic [1:0] {
      CSR_OP_NONE = 2'b00,
      CSR_OP_RW   = 2'b01,
      CSR_OP_RS   = 2'b10,
      CSR_OP_RC   = 2'b11
   } csr_op_e;

   // Synchronous exceptions that can enter a trap.
   typedef enum logic [1:0] {
      EXC_NONE    = 2'b00,
      EXC_ILLEGAL = 2'b01, // mcause 2.
      EXC_BREAK   = 2'b10, // mcause 3.
      EXC_ECALL   = 2'b11  // mcause 11.
   } csr_exc_e;

   typedef struct packed {
      logic        en;
      csr_op_e     op;
      logic        src_sel;   // High selects the zero-extended uimm.
      logic [4:0]  uimm;
      logic [31:0] rs1_value;
      logic [11:0] addr;
   } csr_req_t;

   typedef struct packed {
      csr_exc_e    exc;
      logic [31:0] pc;
      logic        mret;
   } csr_trap_t;

   localparam logic [11:0] CSR_MSTATUS  = 12'h300;
   localparam logic [11:0] CSR_MTVEC    = 12'h305;
   localparam logic [11:0] CSR_MSTATUSH = 12'h310;
   localparam logic [11:0] CSR_MSCRATCH = 12'h340;
   localparam logic [11:0] CSR_MEPC     = 12'h341;
   localparam logic [11:0] CSR_MCAUSE   = 12'h342;
   localparam logic [11:0] CSR_MTVAL    = 12'h343;

   localparam int MSTATUS_MIE_BIT  = 3;
   localparam int MSTATUS_MPIE_BIT = 7;

endpackage

// File: src/csr_mstatus.sv
module csr_mstatus
   import csr_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        en_i,
   input  logic [11:0] addr_i,
   input  logic [31:0] set_i,
   input  logic [31:0] clear_i,
   input  csr_trap_t   trap_i,
   output logic        ack_o,
   output logic [31:0] value_o,
   output logic        mie_o
);

   // Only machine mode exists, so MPP is hard wired to 11.
   localparam logic [31:0] MPP_MACHINE = 32'h0000_1800;

   logic        mie_q;
   logic        mpie_q;
   logic [31:0] write_value;

   assign ack_o = en_i && (addr_i == CSR_MSTATUS);

   always_comb begin
      value_o = MPP_MACHINE;
      value_o[MSTATUS_MIE_BIT]  = mie_q;
      value_o[MSTATUS_MPIE_BIT] = mpie_q;
   end

   assign write_value = (value_o | set_i) & ~clear_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mie_q  <= 1'b0;
         mpie_q <= 1'b0;
      end else if (trap_i.exc != EXC_NONE) begin
         mpie_q <= mie_q; // Interrupt enable is stacked on trap entry.
         mie_q  <= 1'b0;
      end else if (trap_i.mret) begin
         mie_q  <= mpie_q;
         mpie_q <= 1'b1;
      end else if (ack_o) begin
         mie_q  <= write_value[MSTATUS_MIE_BIT];
         mpie_q <= write_value[MSTATUS_MPIE_BIT];
      end
   end

   assign mie_o = mie_q;

endmodule

// File: src/csr_mepc.sv
module csr_mepc
   import csr_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        en_i,
   input  logic [11:0] addr_i,
   input  logic [31:0] set_i,
   input  logic [31:0] clear_i,
   input  csr_trap_t   trap_i,
   output logic        ack_o,
   output logic [31:0] value_o
);

   // Bits 1:0 are not stored, which keeps the value word aligned.
   logic [31:2] epc_q;
   logic [31:0] write_value;

   assign ack_o       = en_i && (addr_i == CSR_MEPC);
   assign value_o     = {epc_q, 2'b00};
   assign write_value = (value_o | set_i) & ~clear_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         epc_q <= '0;
      end else if (trap_i.exc != EXC_NONE) begin
         epc_q <= trap_i.pc[31:2];
      end else if (ack_o) begin
         epc_q <= write_value[31:2];
      end
   end

endmodule

// File: src/csr_mtvec.sv
module csr_mtvec
   import csr_pkg::*;
#(
   parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        en_i,
   input  logic [11:0] addr_i,
   input  logic [31:0] set_i,
   input  logic [31:0] clear_i,
   output logic        ack_o,
   output logic [31:0] value_o
);

   logic [31:2] base_q;
   logic [1:0]  mode_q;  // 0 is direct, 1 is vectored.
   logic [31:0] write_value;

   assign ack_o       = en_i && (addr_i == CSR_MTVEC);
   assign value_o     = {base_q, mode_q};
   assign write_value = (value_o | set_i) & ~clear_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         base_q <= MTVEC_RESET[31:2];
         mode_q <= MTVEC_RESET[1:0];
      end else if (ack_o) begin
         base_q <= write_value[31:2];
         // Modes 2 and 3 are reserved; such a write keeps the old mode.
         if (!write_value[1]) begin
            mode_q <= write_value[1:0];
         end
      end
   end

endmodule

// File: src/csr_mcause.sv
module csr_mcause
   import csr_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        en_i,
   input  logic [11:0] addr_i,
   input  logic [31:0] set_i,
   input  logic [31:0] clear_i,
   input  csr_trap_t   trap_i,
   output logic        ack_o,
   output logic [31:0] value_o
);

   logic        intr_q;  // Bit 31 of mcause.
   logic [3:0]  code_q;
   logic [31:0] write_value;

   function automatic logic [3:0] exc_code(csr_exc_e exc);
      unique case (exc)
         EXC_ILLEGAL: return 4'd2;
         EXC_BREAK:   return 4'd3;
         EXC_ECALL:   return 4'd11;
         default:     return 4'd0;
      endcase
   endfunction

   assign ack_o       = en_i && (addr_i == CSR_MCAUSE);
   assign value_o     = {intr_q, 27'b0, code_q};
   assign write_value = (value_o | set_i) & ~clear_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         intr_q <= 1'b0;
         code_q <= '0;
      end else if (trap_i.exc != EXC_NONE) begin
         intr_q <= 1'b0; // Only synchronous exceptions reach this unit.
         code_q <= exc_code(trap_i.exc);
      end else if (ack_o) begin
         intr_q <= write_value[31];
         code_q <= write_value[3:0];
      end
   end

endmodule

// File: src/csr_mscratch.sv
module csr_mscratch
   import csr_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        en_i,
   input  logic [11:0] addr_i,
   input  logic [31:0] set_i,
   input  logic [31:0] clear_i,
   output logic        ack_o,
   output logic [31:0] value_o
);

   logic [31:0] scratch_q;

   assign ack_o   = en_i && (addr_i == CSR_MSCRATCH);
   assign value_o = scratch_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         scratch_q <= '0;
      end else if (ack_o) begin
         scratch_q <= (scratch_q | set_i) & ~clear_i; // Every bit is writable.
      end
   end

endmodule

// File: src/csr_unit.sv
module csr_unit
   import csr_pkg::*;
#(
   parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
   input  logic        clk_i,
   input  logic        rst_n_i,

   input  csr_req_t    req_i,
   input  csr_trap_t   trap_i,

   output logic [31:0] read_o,
   output logic        illegal_o,

   output logic [31:0] mtvec_o,
   output logic [31:0] mepc_o,
   output logic        mie_o
);

   logic [31:0] source;
   logic [31:0] set_mask;
   logic [31:0] clear_mask;

   logic        mstatus_ack, mepc_ack, mtvec_ack, mcause_ack, mscratch_ack;
   logic [31:0] mstatus_value, mepc_value, mtvec_value, mcause_value, mscratch_value;
   logic        zero_ack;
   logic        any_ack;

   assign source = req_i.src_sel ? {27'b0, req_i.uimm} : req_i.rs1_value;

   always_comb begin
      set_mask   = '0;
      clear_mask = '0;
      unique case (req_i.op)
         CSR_OP_RW: begin
            set_mask   = source;
            clear_mask = ~source;
         end
         CSR_OP_RS: set_mask = source;
         CSR_OP_RC: clear_mask = source;
         default: ; // A plain read leaves every register as it is.
      endcase
   end

   csr_mstatus u_mstatus (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (req_i.en),
      .addr_i  (req_i.addr),
      .set_i   (set_mask),
      .clear_i (clear_mask),
      .trap_i  (trap_i),
      .ack_o   (mstatus_ack),
      .value_o (mstatus_value),
      .mie_o   (mie_o)
   );

   csr_mepc u_mepc (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (req_i.en),
      .addr_i  (req_i.addr),
      .set_i   (set_mask),
      .clear_i (clear_mask),
      .trap_i  (trap_i),
      .ack_o   (mepc_ack),
      .value_o (mepc_value)
   );

   csr_mtvec #(
      .MTVEC_RESET (MTVEC_RESET)
   ) u_mtvec (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (req_i.en),
      .addr_i  (req_i.addr),
      .set_i   (set_mask),
      .clear_i (clear_mask),
      .ack_o   (mtvec_ack),
      .value_o (mtvec_value)
   );

   csr_mcause u_mcause (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (req_i.en),
      .addr_i  (req_i.addr),
      .set_i   (set_mask),
      .clear_i (clear_mask),
      .trap_i  (trap_i),
      .ack_o   (mcause_ack),
      .value_o (mcause_value)
   );

   csr_mscratch u_mscratch (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (req_i.en),
      .addr_i  (req_i.addr),
      .set_i   (set_mask),
      .clear_i (clear_mask),
      .ack_o   (mscratch_ack),
      .value_o (mscratch_value)
   );

   // mstatush and mtval answer with zero and drop writes.
   assign zero_ack = req_i.en && (req_i.addr == CSR_MSTATUSH || req_i.addr == CSR_MTVAL);

   assign any_ack = mstatus_ack | mepc_ack | mtvec_ack | mcause_ack | mscratch_ack | zero_ack;

   assign read_o = ({32{mstatus_ack}}  & mstatus_value)
                 | ({32{mepc_ack}}     & mepc_value)
                 | ({32{mtvec_ack}}    & mtvec_value)
                 | ({32{mcause_ack}}   & mcause_value)
                 | ({32{mscratch_ack}} & mscratch_value);

   assign illegal_o = req_i.en && !any_ack;

   assign mtvec_o = mtvec_value;
   assign mepc_o  = mepc_value;

endmodule

// File: sim/csr_unit_chk.sv
module csr_unit_chk
   import csr_pkg::*;
(
   input logic        clk_i,
   input logic        rst_n_i,
   input csr_req_t    req_i,
   input logic [31:0] read_o,
   input logic        illegal_o,
   input logic [31:0] mtvec_o,
   input logic [31:0] mepc_o,
   input logic [5:0]  ack_i
);

   timeunit 1ns;
   timeprecision 1ps;

   int unsigned error_count = 0; // Failed assertions so far.

   // No access may be flagged while the bus is idle.
   idle_not_illegal_a: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !req_i.en |-> !illegal_o)
   else begin
      error_count++;
      $error("illegal_o is high while no request is active");
   end

   idle_read_zero_a: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !req_i.en |-> read_o == '0)
   else begin
      error_count++;
      $error("read_o is not zero while no request is active");
   end

   mepc_aligned_a: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) mepc_o[1:0] == 2'b00)
   else begin
      error_count++;
      $error("mepc_o is not word aligned");
   end

   mtvec_mode_legal_a: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !mtvec_o[1])
   else begin
      error_count++;
      $error("mtvec_o holds a reserved mode");
   end

   // Each address belongs to one register at most.
   single_ack_a: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) $onehot0(ack_i))
   else begin
      error_count++;
      $error("more than one register acknowledged the same access");
   end

endmodule

// File: sim/csr_unit_tb.sv
module csr_unit_tb
   import csr_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] MTVEC_RESET = 32'h0000_0201;
   localparam int          N_REQ       = 100;
   localparam int          MAX_CYCLES  = 4 * N_REQ + 50;
   localparam csr_trap_t   NO_TRAP     = '0;

   logic        clk;
   logic        rst_n;
   csr_req_t    req;
   csr_trap_t   trap;
   logic [31:0] rdata;
   logic        illegal;
   logic [31:0] mtvec_out;
   logic [31:0] mepc_out;
   logic        mie_out;

   logic [31:0] lfsr_state = 32'h168e_7bc0;
   int          cycles     = 0;

   // Reference model of the machine-mode registers.
   logic        ref_mie      = 1'b0;
   logic        ref_mpie     = 1'b0;
   logic [31:0] ref_mepc     = '0;
   logic [31:0] ref_mtvec    = MTVEC_RESET;
   logic [31:0] ref_mcause   = '0;
   logic [31:0] ref_mscratch = '0;

   csr_unit #(
      .MTVEC_RESET (MTVEC_RESET)
   ) dut0 (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .req_i     (req),
      .trap_i    (trap),
      .read_o    (rdata),
      .illegal_o (illegal),
      .mtvec_o   (mtvec_out),
      .mepc_o    (mepc_out),
      .mie_o     (mie_out)
   );

   bind csr_unit csr_unit_chk u_chk (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .req_i     (req_i),
      .read_o    (read_o),
      .illegal_o (illegal_o),
      .mtvec_o   (mtvec_o),
      .mepc_o    (mepc_o),
      .ack_i     ({mstatus_ack, mepc_ack, mtvec_ack, mcause_ack, mscratch_ack, zero_ack})
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         stop_with_failure($sformatf("test timed out after %0d cycles", cycles));
      end
   end

   task automatic stop_with_failure(string line);
      $display("%s", line);
      $display("** FAIL **");
      $fatal(1, "simulation stopped");
   endtask

   // Taps 32, 22, 2 and 1; one step per bit handed out.
   function automatic logic [31:0] take_bits(int n);
      logic [31:0] bits;
      logic        feedback;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], feedback};
         bits       = {bits[30:0], feedback};
      end
      return bits;
   endfunction

   function automatic logic [31:0] csr_result(csr_op_e op, logic [31:0] old, logic [31:0] src);
      case (op)
         CSR_OP_RW: return src;
         CSR_OP_RS: return old | src;
         CSR_OP_RC: return old & ~src;
         default:   return old;
      endcase
   endfunction

   function automatic logic [31:0] expected_read(logic [11:0] addr, output logic mapped);
      mapped = 1'b1;
      case (addr)
         CSR_MSTATUS:  return 32'h0000_1800 | {24'b0, ref_mpie, 3'b0, ref_mie, 3'b0};
         CSR_MTVEC:    return ref_mtvec;
         CSR_MEPC:     return ref_mepc;
         CSR_MCAUSE:   return ref_mcause;
         CSR_MSCRATCH: return ref_mscratch;
         CSR_MSTATUSH, CSR_MTVAL: return '0;
         default: begin
            mapped = 1'b0;
            return '0;
         end
      endcase
   endfunction

   function automatic string reg_name(logic [11:0] addr);
      case (addr)
         CSR_MSTATUS:  return "mstatus";
         CSR_MTVEC:    return "mtvec";
         CSR_MEPC:     return "mepc";
         CSR_MCAUSE:   return "mcause";
         CSR_MSCRATCH: return "mscratch";
         CSR_MSTATUSH: return "mstatush";
         CSR_MTVAL:    return "mtval";
         default:      return $sformatf("unmapped csr %h", addr);
      endcase
   endfunction

   task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
      assert (got === exp)
      else stop_with_failure($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                                       $time, what, got, exp));
   endtask

   task automatic update_model(csr_req_t r, csr_trap_t t);
      logic [31:0] src;
      logic [31:0] wr;
      logic        mapped;
      src = r.src_sel ? {27'b0, r.uimm} : r.rs1_value;
      wr  = csr_result(r.op, expected_read(r.addr, mapped), src);
      if (r.en) begin
         case (r.addr)
            CSR_MSCRATCH: ref_mscratch = wr;
            CSR_MTVEC:    ref_mtvec = {wr[31:2], wr[1] ? ref_mtvec[1:0] : wr[1:0]};
            CSR_MEPC:     if (t.exc == EXC_NONE) ref_mepc = wr & ~32'h3;
            CSR_MCAUSE:   if (t.exc == EXC_NONE) ref_mcause = wr & 32'h8000_000f;
            CSR_MSTATUS: begin
               if (t.exc == EXC_NONE && !t.mret) begin
                  ref_mie  = wr[3];
                  ref_mpie = wr[7];
               end
            end
            default: ;
         endcase
      end
      if (t.exc != EXC_NONE) begin
         ref_mepc   = t.pc & ~32'h3;
         ref_mcause = (t.exc == EXC_ILLEGAL) ? 32'd2 : (t.exc == EXC_BREAK) ? 32'd3 : 32'd11;
         ref_mpie   = ref_mie;
         ref_mie    = 1'b0;
      end else if (t.mret) begin
         ref_mie  = ref_mpie;
         ref_mpie = 1'b1;
      end
   endtask

   // One request per cycle; outputs are compared at the falling edge.
   task automatic issue(csr_req_t r, csr_trap_t t);
      logic [31:0] exp_read;
      logic        mapped;
      @(posedge clk);
      req  <= r;
      trap <= t;
      @(negedge clk);
      exp_read = expected_read(r.addr, mapped);
      if (!r.en) exp_read = '0;
      check_value(reg_name(r.addr), rdata, exp_read);
      check_value("illegal_o", {31'b0, illegal}, {31'b0, r.en && !mapped});
      check_value("mtvec_o", mtvec_out, ref_mtvec);
      check_value("mepc_o", mepc_out, ref_mepc);
      check_value("mie_o", {31'b0, mie_out}, {31'b0, ref_mie});
      assert (dut0.u_chk.error_count == 0)
      else stop_with_failure("a protocol assertion in the checker failed");
      update_model(r, t);
   endtask

   function automatic csr_req_t make_req(csr_op_e op, logic [11:0] addr, logic [31:0] value,
                                         logic use_imm);
      csr_req_t r;
      r.en        = 1'b1;
      r.op        = op;
      r.src_sel   = use_imm;
      r.uimm      = value[4:0];
      r.rs1_value = value;
      r.addr      = addr;
      return r;
   endfunction

   task automatic write_csr(csr_op_e op, logic [11:0] addr, logic [31:0] value, logic use_imm);
      issue(make_req(op, addr, value, use_imm), NO_TRAP);
   endtask

   task automatic read_csr(logic [11:0] addr);
      issue(make_req(CSR_OP_RS, addr, 32'b0, 1'b0), NO_TRAP); // Set with zero changes nothing.
   endtask

   initial begin
      csr_op_e     op;
      logic [11:0] addr;
      logic [31:0] value;
      logic        sel;
      logic        mapped;
      csr_trap_t   t;
      rst_n = 1'b0;
      req   = '0;
      trap  = '0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      read_csr(CSR_MSTATUS);
      read_csr(CSR_MTVEC);
      read_csr(CSR_MEPC);
      read_csr(CSR_MCAUSE);
      read_csr(CSR_MSCRATCH);

      repeat (40) begin
         case (take_bits(2))
            32'd1:   op = CSR_OP_RS;
            32'd2:   op = CSR_OP_RC;
            default: op = CSR_OP_RW;
         endcase
         value = take_bits(32);
         sel   = take_bits(1) != 0;
         write_csr(op, CSR_MSCRATCH, value, sel);
      end
      read_csr(CSR_MSCRATCH);

      write_csr(CSR_OP_RW, CSR_MTVEC, 32'h1000_0001, 1'b0);
      write_csr(CSR_OP_RW, CSR_MTVEC, 32'h2000_0002, 1'b0);
      write_csr(CSR_OP_RW, CSR_MTVEC, 32'h3000_0003, 1'b0);
      write_csr(CSR_OP_RC, CSR_MTVEC, 32'h0000_0001, 1'b1);
      write_csr(CSR_OP_RS, CSR_MTVEC, 32'h0000_0002, 1'b1);
      read_csr(CSR_MTVEC);
      write_csr(CSR_OP_RW, CSR_MEPC, take_bits(32) | 32'h3, 1'b0);
      write_csr(CSR_OP_RS, CSR_MEPC, 32'h0000_0003, 1'b1);
      read_csr(CSR_MEPC);
      write_csr(CSR_OP_RW, CSR_MCAUSE, 32'hffff_ffff, 1'b0);
      read_csr(CSR_MCAUSE);
      write_csr(CSR_OP_RC, CSR_MCAUSE, 32'h8000_0005, 1'b0);
      read_csr(CSR_MCAUSE);

      write_csr(CSR_OP_RS, CSR_MSTATUS, 32'h0000_0008, 1'b1); // Enable MIE first.
      for (int i = 1; i < 4; i++) begin
         t     = NO_TRAP;
         t.exc = csr_exc_e'(i);
         t.pc  = take_bits(32);
         issue('0, t);
         read_csr(CSR_MCAUSE);
         read_csr(CSR_MEPC);
         read_csr(CSR_MSTATUS);
         t      = NO_TRAP;
         t.mret = 1'b1;
         issue('0, t);
         read_csr(CSR_MSTATUS);
      end
      value = take_bits(32);
      t     = NO_TRAP;
      t.exc = EXC_ECALL;
      t.pc  = take_bits(32);
      issue(make_req(CSR_OP_RW, CSR_MEPC, value, 1'b0), t);
      read_csr(CSR_MEPC);
      read_csr(CSR_MCAUSE);

      write_csr(CSR_OP_RW, CSR_MSTATUSH, take_bits(32), 1'b0);
      read_csr(CSR_MSTATUSH);
      write_csr(CSR_OP_RS, CSR_MTVAL, take_bits(32), 1'b0);
      read_csr(CSR_MTVAL);
      repeat (8) begin
         do begin
            addr = 12'(take_bits(12));
            void'(expected_read(addr, mapped));
         end while (mapped);
         write_csr(CSR_OP_RW, addr, take_bits(32), 1'b0);
      end
      read_csr(CSR_MSTATUS);
      read_csr(CSR_MTVEC);
      read_csr(CSR_MEPC);
      read_csr(CSR_MCAUSE);
      read_csr(CSR_MSCRATCH);
      issue('0, NO_TRAP);
      issue('0, NO_TRAP);
      @(negedge clk); // The checker samples the last request at the edge in between.

      if (dut0.u_chk.error_count != 0) begin
         stop_with_failure("a protocol assertion in the checker failed");
      end else begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

// File: csr_unit.f
src/csr_pkg.sv
src/csr_mstatus.sv
src/csr_mepc.sv
src/csr_mtvec.sv
src/csr_mcause.sv
src/csr_mscratch.sv
src/csr_unit.sv
sim/csr_unit_chk.sv
sim/csr_unit_tb.sv
